// File: tb.f
+incdir+rtl
rtl/opnet_pkg.sv
rtl/forward.sv
rtl/stage_pipe.sv
rtl/reg_file.sv
rtl/operand_select.sv
rtl/opnet_top.sv
verification/opnet_tb.sv

// File: Makefile
# Verilator flow for the operand network testbench

VERILATOR ?= verilator
TOP       ?= opnet_tb
FILELIST  ?= tb.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_MSG  := ** PASS **

SRCS := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)
SIM  := $(BUILD)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/opnet_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "opnet_defines.svh"

module opnet_tb;

  logic                 clk;
  logic                 arst_n;
  logic                 issue_valid;
  opnet_pkg::issue_t    issue;
  opnet_pkg::word_t     ex_result;
  opnet_pkg::word_t     mem_data;
  opnet_pkg::word_t     fex_result;
  logic                 ex_valid;
  logic                 fex_valid;
  opnet_pkg::operands_t ex_ops;
  opnet_pkg::operands_t fex_ops;
  opnet_pkg::word_t     id_branch_op;

  // Reference register files and shadow stages
  opnet_pkg::word_t  int_rf [`OPNET_NREGS];
  opnet_pkg::word_t  fp_rf [`OPNET_NREGS];
  opnet_pkg::stage_t m_id_ex;
  opnet_pkg::stage_t m_id_fex;
  opnet_pkg::stage_t m_ex_mem;
  opnet_pkg::stage_t m_mem_wb;
  opnet_pkg::stage_t m_fex_wb;

  logic [31:0] seed;
  int          errors;
  int          checks;

  opnet_top i_dut (
    .clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .issue(issue),
    .ex_result(ex_result), .mem_data(mem_data), .fex_result(fex_result),
    .ex_valid(ex_valid), .fex_valid(fex_valid), .ex_ops(ex_ops), .fex_ops(fex_ops),
    .id_branch_op(id_branch_op)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic int pick(input int n);
    return int'((lcg_next() >> 8) % n);
  endfunction

  // Kinds 0 int alu, 1 int load, 2 int store, 3 fp op, 4 fp load,
  // 5 fp store, 6 int to fp, 7 fp to int, others a branch
  function automatic opnet_pkg::issue_t make_inst(input int kind, input int span);
    opnet_pkg::issue_t ins;
    ins      = '0;
    ins.reg1 = opnet_pkg::reg_idx_t'(pick(span));
    ins.reg2 = opnet_pkg::reg_idx_t'(pick(span));
    ins.regw = opnet_pkg::reg_idx_t'(pick(span));
    case (kind)
      0: ins.ctrl = 7'b1000000;
      1: ins.ctrl = 7'b1001100;
      2: ins.ctrl = 7'b0010000;
      3: ins.ctrl = 7'b1100000;
      4: ins.ctrl = 7'b0101100;
      5: ins.ctrl = 7'b0110000;
      6: ins.ctrl = 7'b1100001;
      7: ins.ctrl = 7'b1100010;
      default: ins.ctrl = 7'b0000000;
    endcase
    return ins;
  endfunction

  function automatic logic fp_load_in_wb();
    return !m_mem_wb.ctrl.regw && m_mem_wb.ctrl.mem_to_reg && m_mem_wb.ctrl.fp_inst;
  endfunction

  // EX priority is MEM, then WB, then FEX/WB
  function automatic opnet_pkg::word_t ex_operand(input opnet_pkg::reg_idx_t src,
                                                  input opnet_pkg::word_t captured);
    logic mem_hit;
    logic wb_hit;
    logic fex_hit;
    mem_hit = m_ex_mem.ctrl.regw && m_ex_mem.regw == src;
    wb_hit  = ((m_mem_wb.ctrl.regw && !m_mem_wb.ctrl.fp_inst) ||
               (fp_load_in_wb() && m_id_ex.ctrl.fp_inst)) && m_mem_wb.regw == src;
    fex_hit = m_fex_wb.ctrl.regw && m_fex_wb.regw == src &&
              (m_fex_wb.ctrl.fp_int_cvt[1] || (m_id_ex.ctrl.fp_inst && m_id_ex.ctrl.mem_write));
    return mem_hit ? m_ex_mem.data : wb_hit ? m_mem_wb.data : fex_hit ? m_fex_wb.data : captured;
  endfunction

  function automatic opnet_pkg::word_t fex_operand(input opnet_pkg::reg_idx_t src,
                                                   input opnet_pkg::word_t captured);
    logic wb_hit;
    logic mem_hit;
    logic ld_hit;
    wb_hit  = m_fex_wb.ctrl.regw && !m_fex_wb.ctrl.mem_read && m_id_fex.ctrl.fp_inst &&
              m_fex_wb.regw == src;
    mem_hit = m_ex_mem.ctrl.regw && m_id_fex.ctrl.fp_int_cvt[0] && m_ex_mem.regw == src;
    ld_hit  = fp_load_in_wb() && m_id_fex.ctrl.fp_inst && m_mem_wb.regw == src;
    return wb_hit ? m_fex_wb.data : mem_hit ? m_ex_mem.data : ld_hit ? m_mem_wb.data : captured;
  endfunction

  task automatic compare_word(input string what, input opnet_pkg::word_t got,
                              input opnet_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic model_cycle();
    opnet_pkg::stage_t   nxt;
    opnet_pkg::reg_idx_t int_wa;
    opnet_pkg::reg_idx_t fp_wa;
    opnet_pkg::word_t    int_wd;
    opnet_pkg::word_t    fp_wd;
    opnet_pkg::word_t    ia;
    opnet_pkg::word_t    ib;
    opnet_pkg::word_t    fa;
    opnet_pkg::word_t    fb;
    opnet_pkg::word_t    exp_br;
    logic                fex_int;
    logic                fex_fp;
    logic                int_we;
    logic                fp_we;
    logic                to_fex;
    // Write-back this cycle with FEX/WB ahead of MEM/WB
    fex_int = m_fex_wb.ctrl.regw && m_fex_wb.ctrl.fp_int_cvt[1];
    fex_fp  = m_fex_wb.ctrl.regw && !m_fex_wb.ctrl.fp_int_cvt[1];
    int_we  = fex_int || (m_mem_wb.ctrl.regw && !m_mem_wb.ctrl.fp_inst);
    fp_we   = fex_fp || fp_load_in_wb();
    int_wa  = fex_int ? m_fex_wb.regw : m_mem_wb.regw;
    int_wd  = fex_int ? m_fex_wb.data : m_mem_wb.data;
    fp_wa   = fex_fp ? m_fex_wb.regw : m_mem_wb.regw;
    fp_wd   = fex_fp ? m_fex_wb.data : m_mem_wb.data;
    // ID reads see a same-cycle write
    ia = (int_we && int_wa == issue.reg1) ? int_wd : int_rf[issue.reg1];
    ib = (int_we && int_wa == issue.reg2) ? int_wd : int_rf[issue.reg2];
    fa = (fp_we && fp_wa == issue.reg1) ? fp_wd : fp_rf[issue.reg1];
    fb = (fp_we && fp_wa == issue.reg2) ? fp_wd : fp_rf[issue.reg2];
    exp_br = (m_ex_mem.ctrl.regw && !m_ex_mem.ctrl.fp_inst && m_ex_mem.regw == issue.reg1) ?
             m_ex_mem.data :
             (fex_int && m_fex_wb.ctrl.fp_inst && m_fex_wb.regw == issue.reg1) ?
             m_fex_wb.data : ia;

    compare_word("ex_valid", opnet_pkg::word_t'(ex_valid), opnet_pkg::word_t'(m_id_ex.valid));
    compare_word("fex_valid", opnet_pkg::word_t'(fex_valid), opnet_pkg::word_t'(m_id_fex.valid));
    compare_word("id_branch_op", id_branch_op, exp_br);
    if (m_id_ex.valid) begin
      compare_word("ex_ops.op_a", ex_ops.op_a, ex_operand(m_id_ex.reg1, m_id_ex.data));
      compare_word("ex_ops.op_b", ex_ops.op_b, ex_operand(m_id_ex.reg2, m_id_ex.op_b));
    end
    if (m_id_fex.valid) begin
      compare_word("fex_ops.op_a", fex_ops.op_a, fex_operand(m_id_fex.reg1, m_id_fex.data));
      compare_word("fex_ops.op_b", fex_ops.op_b, fex_operand(m_id_fex.reg2, m_id_fex.op_b));
    end

    // Stage contents of the issued instruction
    to_fex     = issue.ctrl.fp_inst && !issue.ctrl.mem_read && !issue.ctrl.mem_write;
    nxt        = '0;
    nxt.valid  = 1'b1;
    nxt.regw   = issue.regw;
    nxt.reg1   = issue.reg1;
    nxt.reg2   = issue.reg2;
    nxt.ctrl   = issue.ctrl;
    if (to_fex) begin
      nxt.data = issue.ctrl.fp_int_cvt[0] ? ia : fa;
      nxt.op_b = issue.ctrl.fp_int_cvt[0] ? ib : fb;
    end else begin
      nxt.data = ia;
      nxt.op_b = issue.ctrl.fp_inst ? fb : ib;
    end

    if (int_we) int_rf[int_wa] = int_wd;
    if (fp_we) fp_rf[fp_wa] = fp_wd;
    m_mem_wb = m_ex_mem;
    if (m_ex_mem.ctrl.mem_to_reg) m_mem_wb.data = mem_data;
    m_ex_mem = m_id_ex;
    if (m_id_ex.valid) m_ex_mem.data = ex_result;
    m_fex_wb = m_id_fex;
    if (m_id_fex.valid) m_fex_wb.data = fex_result;
    m_id_ex  = (issue_valid && !to_fex) ? nxt : '0;
    m_id_fex = (issue_valid && to_fex) ? nxt : '0;
  endtask

  // Mode 0 idle, 1 integer chains, 2 mixed traffic, 3 mixed with gaps
  task automatic run_cycle(input int mode);
    int kind;
    @(negedge clk);
    kind        = (mode == 1) ? pick(2) : pick(9);
    issue       = make_inst(kind, (mode == 1) ? 4 : 8);
    issue_valid = (mode == 1 || mode == 2) || (mode == 3 && pick(10) < 7);
    ex_result   = lcg_next();
    mem_data    = lcg_next();
    fex_result  = lcg_next();
    #5;
    model_cycle();
  endtask

  initial begin
    int n;
    clk         = 1'b0;
    arst_n      = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    ex_result   = '0;
    mem_data    = '0;
    fex_result  = '0;
    seed        = 32'd54431;
    errors      = 0;
    checks      = 0;
    m_id_ex     = '0;
    m_id_fex    = '0;
    m_ex_mem    = '0;
    m_mem_wb    = '0;
    m_fex_wb    = '0;
    for (int i = 0; i < `OPNET_NREGS; i++) begin
      int_rf[i] = '0;
      fp_rf[i]  = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Quiet pipe and zero reads before any strobe
    repeat (6) run_cycle(0);

    run_cycle(1);
    n = 0;
    while (!ex_valid && n < 100) begin
      run_cycle(0);
      n++;
    end
    if (!ex_valid) begin
      $display("Timeout: ex_valid never rose after the first integer issue");
      $display("** FAIL **");
    end else begin
      repeat (80) run_cycle(1);
      repeat (300) run_cycle(2);
      repeat (1000) run_cycle(3);
      repeat (4) run_cycle(0);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/opnet_top.sv
`timescale 1ns/1ps
`default_nettype none

module opnet_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 issue_valid,
  input  opnet_pkg::issue_t    issue,
  input  opnet_pkg::word_t     ex_result,
  input  opnet_pkg::word_t     mem_data,
  input  opnet_pkg::word_t     fex_result,
  output logic                 ex_valid,
  output logic                 fex_valid,
  output opnet_pkg::operands_t ex_ops,
  output opnet_pkg::operands_t fex_ops,
  output opnet_pkg::word_t     id_branch_op
);

  opnet_pkg::stage_t    id_ex;
  opnet_pkg::stage_t    id_fex;
  opnet_pkg::stage_t    ex_mem;
  opnet_pkg::stage_t    mem_wb;
  opnet_pkg::stage_t    fex_wb;
  opnet_pkg::fwd_sel_t  fwd_sel;
  opnet_pkg::operands_t int_rd;
  opnet_pkg::operands_t fp_rd;
  opnet_pkg::operands_t id_int_ops;
  opnet_pkg::operands_t id_fp_ops;
  opnet_pkg::reg_idx_t  int_waddr;
  opnet_pkg::reg_idx_t  fp_waddr;
  opnet_pkg::word_t     int_wdata;
  opnet_pkg::word_t     fp_wdata;
  logic                 fex_int_wr;
  logic                 fex_fp_wr;
  logic                 wb_int_wr;
  logic                 wb_fp_ld;

  // Write sources for each file
  assign fex_int_wr = fex_wb.ctrl.regw & fex_wb.ctrl.fp_int_cvt[1];
  assign fex_fp_wr  = fex_wb.ctrl.regw & ~fex_wb.ctrl.fp_int_cvt[1];
  assign wb_int_wr  = mem_wb.ctrl.regw & ~mem_wb.ctrl.fp_inst;
  assign wb_fp_ld   = ~mem_wb.ctrl.regw & mem_wb.ctrl.mem_to_reg & mem_wb.ctrl.fp_inst;

  // FEX/WB takes the port over MEM/WB
  assign int_waddr = fex_int_wr ? fex_wb.regw : mem_wb.regw;
  assign int_wdata = fex_int_wr ? fex_wb.data : mem_wb.data;
  assign fp_waddr  = fex_fp_wr ? fex_wb.regw : mem_wb.regw;
  assign fp_wdata  = fex_fp_wr ? fex_wb.data : mem_wb.data;

  assign ex_valid  = id_ex.valid;
  assign fex_valid = id_fex.valid;

  forward i_forward (
    .if_id(issue), .id_ex(id_ex), .id_fex(id_fex), .ex_mem(ex_mem), .mem_wb(mem_wb),
    .fex_wb(fex_wb), .fwd_sel(fwd_sel)
  );

  stage_pipe i_stage_pipe (
    .clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .issue(issue),
    .id_a(id_int_ops), .id_b(id_fp_ops), .ex_result(ex_result), .mem_data(mem_data),
    .fex_result(fex_result), .id_ex(id_ex), .id_fex(id_fex), .ex_mem(ex_mem),
    .mem_wb(mem_wb), .fex_wb(fex_wb)
  );

  operand_select i_operand_select (
    .fwd_sel(fwd_sel), .if_id(issue), .int_rd(int_rd), .fp_rd(fp_rd),
    .int_wdata(int_wdata), .fp_wdata(fp_wdata), .id_ex(id_ex), .id_fex(id_fex),
    .ex_mem(ex_mem), .mem_wb(mem_wb), .fex_wb(fex_wb), .id_int_ops(id_int_ops),
    .id_fp_ops(id_fp_ops), .ex_ops(ex_ops), .fex_ops(fex_ops), .id_branch_op(id_branch_op)
  );

  reg_file i_int_rf (
    .clk(clk), .arst_n(arst_n), .we(fex_int_wr | wb_int_wr), .waddr(int_waddr),
    .wdata(int_wdata), .raddr1(issue.reg1), .raddr2(issue.reg2),
    .rdata1(int_rd.op_a), .rdata2(int_rd.op_b)
  );

  reg_file i_fp_rf (
    .clk(clk), .arst_n(arst_n), .we(fex_fp_wr | wb_fp_ld), .waddr(fp_waddr),
    .wdata(fp_wdata), .raddr1(issue.reg1), .raddr2(issue.reg2),
    .rdata1(fp_rd.op_a), .rdata2(fp_rd.op_b)
  );

endmodule

`default_nettype wire

// File: rtl/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
  input  opnet_pkg::fwd_sel_t  fwd_sel,
  input  opnet_pkg::issue_t    if_id,
  input  opnet_pkg::operands_t int_rd,
  input  opnet_pkg::operands_t fp_rd,
  input  opnet_pkg::word_t     int_wdata,
  input  opnet_pkg::word_t     fp_wdata,
  input  opnet_pkg::stage_t    id_ex,
  input  opnet_pkg::stage_t    id_fex,
  input  opnet_pkg::stage_t    ex_mem,
  input  opnet_pkg::stage_t    mem_wb,
  input  opnet_pkg::stage_t    fex_wb,
  output opnet_pkg::operands_t id_int_ops,
  output opnet_pkg::operands_t id_fp_ops,
  output opnet_pkg::operands_t ex_ops,
  output opnet_pkg::operands_t fex_ops,
  output opnet_pkg::word_t     id_branch_op
);

  logic fex_int_wr;
  logic fex_fp_wr;
  logic fp_ld_wr;
  logic int_hit1;
  logic int_hit2;
  logic fp_hit1;
  logic fp_hit2;

  // Which writer owns each file port this cycle, FEX/WB wins
  assign fex_int_wr = fex_wb.ctrl.regw & fex_wb.ctrl.fp_int_cvt[1];
  assign fex_fp_wr  = fex_wb.ctrl.regw & ~fex_wb.ctrl.fp_int_cvt[1];
  assign fp_ld_wr   = ~mem_wb.ctrl.regw & mem_wb.ctrl.mem_to_reg & mem_wb.ctrl.fp_inst &
                      ~fex_fp_wr;

  // Bypass only when the matching stage really owns the write port
  assign int_hit1 = (fwd_sel.bypass_reg1 & ~fex_int_wr) | (fwd_sel.fp_int_bypass_reg1 & fex_int_wr);
  assign int_hit2 = (fwd_sel.bypass_reg2 & ~fex_int_wr) | (fwd_sel.fp_int_bypass_reg2 & fex_int_wr);
  assign fp_hit1  = (fwd_sel.fp_bypass_reg1 & fex_fp_wr) | (fp_ld_wr & (mem_wb.regw == if_id.reg1));
  assign fp_hit2  = (fwd_sel.fp_bypass_reg2 & fex_fp_wr) | (fp_ld_wr & (mem_wb.regw == if_id.reg2));

  assign id_int_ops.op_a = int_hit1 ? int_wdata : int_rd.op_a;
  assign id_int_ops.op_b = int_hit2 ? int_wdata : int_rd.op_b;
  assign id_fp_ops.op_a  = fp_hit1 ? fp_wdata : fp_rd.op_a;
  assign id_fp_ops.op_b  = fp_hit2 ? fp_wdata : fp_rd.op_b;

  // Branch compare value
  assign id_branch_op = fwd_sel.frwrd_ex_id_opa  ? ex_mem.data :
                        fwd_sel.frwrd_fex_id_opa ? fex_wb.data :
                        id_int_ops.op_a;

  // EX operands: MEM, then integer WB, then FEX WB
  assign ex_ops.op_a = fwd_sel.frwrd_mem_ex_opa   ? ex_mem.data :
                       fwd_sel.frwrd_wb_ex_opa    ? mem_wb.data :
                       fwd_sel.frwrd_fp_wb_ex_opa ? fex_wb.data :
                       id_ex.data;
  assign ex_ops.op_b = fwd_sel.frwrd_mem_ex_opb   ? ex_mem.data :
                       fwd_sel.frwrd_wb_ex_opb    ? mem_wb.data :
                       fwd_sel.frwrd_fp_wb_ex_opb ? fex_wb.data :
                       id_ex.op_b;

  // FEX operands
  assign fex_ops.op_a = fwd_sel.frwrd_wb_fex_opa    ? fex_wb.data :
                        fwd_sel.frwrd_mem_fex_opa   ? ex_mem.data :
                        fwd_sel.frwrd_int_wb_ex_opa ? mem_wb.data :
                        id_fex.data;
  assign fex_ops.op_b = fwd_sel.frwrd_wb_fex_opb    ? fex_wb.data :
                        fwd_sel.frwrd_mem_fex_opb   ? ex_mem.data :
                        fwd_sel.frwrd_int_wb_ex_opb ? mem_wb.data :
                        id_fex.op_b;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "opnet_defines.svh"

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                we,
  input  opnet_pkg::reg_idx_t waddr,
  input  opnet_pkg::word_t    wdata,
  input  opnet_pkg::reg_idx_t raddr1,
  input  opnet_pkg::reg_idx_t raddr2,
  output opnet_pkg::word_t    rdata1,
  output opnet_pkg::word_t    rdata2
);

  opnet_pkg::word_t regs [`OPNET_NREGS];

  // Whole file clears on reset so early reads return zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `OPNET_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Reads see the old value during a write, ID bypass covers that case
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: rtl/stage_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module stage_pipe (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 issue_valid,
  input  opnet_pkg::issue_t    issue,
  input  opnet_pkg::operands_t id_a,
  input  opnet_pkg::operands_t id_b,
  input  opnet_pkg::word_t     ex_result,
  input  opnet_pkg::word_t     mem_data,
  input  opnet_pkg::word_t     fex_result,
  output opnet_pkg::stage_t    id_ex,
  output opnet_pkg::stage_t    id_fex,
  output opnet_pkg::stage_t    ex_mem,
  output opnet_pkg::stage_t    mem_wb,
  output opnet_pkg::stage_t    fex_wb
);

  opnet_pkg::stage_t    issued;
  opnet_pkg::operands_t fex_src;
  logic                 to_fex;

  // Memory ops always take the EX pipe
  assign to_fex  = issue.ctrl.fp_inst & ~issue.ctrl.mem_read & ~issue.ctrl.mem_write;
  assign fex_src = issue.ctrl.fp_int_cvt[0] ? id_a : id_b;

  // id_a is the integer pair, id_b the FP pair
  always_comb begin
    issued      = '0;
    issued.regw = issue.regw;
    issued.reg1 = issue.reg1;
    issued.reg2 = issue.reg2;
    issued.ctrl = issue.ctrl;
    if (to_fex) begin
      issued.data = fex_src.op_a;
      issued.op_b = fex_src.op_b;
    end else begin
      issued.data = id_a.op_a;
      // FP store data comes from the FP file
      issued.op_b = issue.ctrl.fp_inst ? id_b.op_b : id_a.op_b;
    end
    issued.valid = issue_valid;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex  <= '0;
      id_fex <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
      fex_wb <= '0;
    end else begin
      // Bubble when nothing issues into a pipe
      id_ex  <= (issue_valid && !to_fex) ? issued : '0;
      id_fex <= (issue_valid && to_fex) ? issued : '0;

      ex_mem      <= id_ex;
      ex_mem.data <= id_ex.valid ? ex_result : '0;
      ex_mem.op_b <= '0;

      mem_wb      <= ex_mem;
      mem_wb.data <= ex_mem.ctrl.mem_to_reg ? mem_data : ex_mem.data;

      fex_wb      <= id_fex;
      fex_wb.data <= id_fex.valid ? fex_result : '0;
      fex_wb.op_b <= '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/forward.sv
`timescale 1ns/1ps
`default_nettype none

module forward (
  input  opnet_pkg::issue_t   if_id,
  input  opnet_pkg::stage_t   id_ex,
  input  opnet_pkg::stage_t   id_fex,
  input  opnet_pkg::stage_t   ex_mem,
  input  opnet_pkg::stage_t   mem_wb,
  input  opnet_pkg::stage_t   fex_wb,
  output opnet_pkg::fwd_sel_t fwd_sel
);

  logic mem_ex_en;
  logic mem_fex_en;
  logic fp_wb_ex_en;
  logic wb_fex_en;
  logic wb_ex_en;
  logic ld_fex_en;
  logic int_wb_en;

  // Qualifiers shared by the A and B compares
  assign mem_ex_en   = ex_mem.ctrl.regw;
  assign mem_fex_en  = ex_mem.ctrl.regw & id_fex.ctrl.fp_int_cvt[0];
  assign fp_wb_ex_en = fex_wb.ctrl.regw &
                       (fex_wb.ctrl.fp_int_cvt[1] | (id_ex.ctrl.fp_inst & id_ex.ctrl.mem_write));
  assign wb_fex_en   = fex_wb.ctrl.regw & ~fex_wb.ctrl.mem_read & id_fex.ctrl.fp_inst;
  assign int_wb_en   = mem_wb.ctrl.regw & ~mem_wb.ctrl.fp_inst;

  // FP load sitting in MEM/WB
  assign ld_fex_en   = ~mem_wb.ctrl.regw & mem_wb.ctrl.mem_to_reg & mem_wb.ctrl.fp_inst;
  assign wb_ex_en    = int_wb_en | (ld_fex_en & id_ex.ctrl.fp_inst);

  // Into EX
  assign fwd_sel.frwrd_mem_ex_opa   = mem_ex_en & (ex_mem.regw == id_ex.reg1);
  assign fwd_sel.frwrd_mem_ex_opb   = mem_ex_en & (ex_mem.regw == id_ex.reg2);
  assign fwd_sel.frwrd_wb_ex_opa    = wb_ex_en & (mem_wb.regw == id_ex.reg1);
  assign fwd_sel.frwrd_wb_ex_opb    = wb_ex_en & (mem_wb.regw == id_ex.reg2);

  // Converts to int and FP store data come from FEX/WB
  assign fwd_sel.frwrd_fp_wb_ex_opa = fp_wb_ex_en & (fex_wb.regw == id_ex.reg1);
  assign fwd_sel.frwrd_fp_wb_ex_opb = fp_wb_ex_en & (fex_wb.regw == id_ex.reg2);

  // Into FEX
  assign fwd_sel.frwrd_wb_fex_opa    = wb_fex_en & (fex_wb.regw == id_fex.reg1);
  assign fwd_sel.frwrd_wb_fex_opb    = wb_fex_en & (fex_wb.regw == id_fex.reg2);
  assign fwd_sel.frwrd_mem_fex_opa   = mem_fex_en & (ex_mem.regw == id_fex.reg1);
  assign fwd_sel.frwrd_mem_fex_opb   = mem_fex_en & (ex_mem.regw == id_fex.reg2);
  assign fwd_sel.frwrd_int_wb_ex_opa = ld_fex_en & id_fex.ctrl.fp_inst &
                                       (mem_wb.regw == id_fex.reg1);
  assign fwd_sel.frwrd_int_wb_ex_opb = ld_fex_en & id_fex.ctrl.fp_inst &
                                       (mem_wb.regw == id_fex.reg2);

  // Register file bypass in ID
  assign fwd_sel.bypass_reg1        = int_wb_en & (mem_wb.regw == if_id.reg1);
  assign fwd_sel.bypass_reg2        = int_wb_en & (mem_wb.regw == if_id.reg2);
  assign fwd_sel.fp_int_bypass_reg1 = fex_wb.ctrl.regw & fex_wb.ctrl.fp_inst &
                                      (fex_wb.regw == if_id.reg1);
  assign fwd_sel.fp_int_bypass_reg2 = fex_wb.ctrl.regw & fex_wb.ctrl.fp_inst &
                                      (fex_wb.regw == if_id.reg2);
  assign fwd_sel.fp_bypass_reg1     = fex_wb.ctrl.regw & (fex_wb.regw == if_id.reg1);
  assign fwd_sel.fp_bypass_reg2     = fex_wb.ctrl.regw & (fex_wb.regw == if_id.reg2);

  // Branch operand in ID
  assign fwd_sel.frwrd_ex_id_opa  = ex_mem.ctrl.regw & ~ex_mem.ctrl.fp_inst &
                                    (ex_mem.regw == if_id.reg1);
  assign fwd_sel.frwrd_fex_id_opa = fex_wb.ctrl.regw & fex_wb.ctrl.fp_inst &
                                    fex_wb.ctrl.fp_int_cvt[1] & (fex_wb.regw == if_id.reg1);

endmodule

`default_nettype wire

// File: rtl/opnet_pkg.sv
`default_nettype none

`include "opnet_defines.svh"

package opnet_pkg;

  typedef logic [`OPNET_REG_W-1:0] reg_idx_t;
  typedef logic [`OPNET_DATA_W-1:0] word_t;

  // Decoded control bits that travel with an instruction
  typedef struct packed {
    logic       regw;
    logic       fp_inst;
    logic       mem_write;
    logic       mem_read;
    logic       mem_to_reg;
    logic [1:0] fp_int_cvt;  // [0] int sources in FEX, [1] int destination from FEX
  } ctrl_t;

  typedef struct packed {
    reg_idx_t reg1;
    reg_idx_t reg2;
    reg_idx_t regw;
    ctrl_t    ctrl;
  } issue_t;

  // Tag and value of one stage register
  typedef struct packed {
    logic     valid;
    reg_idx_t regw;
    reg_idx_t reg1;
    reg_idx_t reg2;
    ctrl_t    ctrl;
    word_t    data;
    // Second captured ID operand, only meaningful in ID/EX and ID/FEX
    word_t    op_b;
  } stage_t;

  typedef struct packed {
    word_t op_a;
    word_t op_b;
  } operands_t;

  typedef struct packed {
    logic frwrd_mem_ex_opa;
    logic frwrd_mem_ex_opb;
    logic frwrd_wb_ex_opa;
    logic frwrd_wb_ex_opb;
    logic frwrd_ex_id_opa;
    logic frwrd_wb_fex_opa;
    logic frwrd_wb_fex_opb;
    logic frwrd_fp_wb_ex_opa;
    logic frwrd_fp_wb_ex_opb;
    logic frwrd_int_wb_ex_opa;
    logic frwrd_int_wb_ex_opb;
    logic frwrd_mem_fex_opa;
    logic frwrd_mem_fex_opb;
    logic frwrd_fex_id_opa;
    logic bypass_reg1;
    logic bypass_reg2;
    logic fp_bypass_reg1;
    logic fp_bypass_reg2;
    logic fp_int_bypass_reg1;
    logic fp_int_bypass_reg2;
  } fwd_sel_t;

endpackage

`default_nettype wire

// File: rtl/opnet_defines.svh
`ifndef OPNET_DEFINES_SVH
`define OPNET_DEFINES_SVH

// Register index width
`define OPNET_REG_W 5

// Operand and result width
`define OPNET_DATA_W 32

// Entries per register file
`define OPNET_NREGS 32

`endif
